// ==== rtl/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Instruction memory depth as a word address width.
`define IMEM_AW 6

// Data memory depth as a word address width.
`define DMEM_AW 6

// Address of the first instruction after reset.
`define RESET_PC 32'h0000_0000

`endif

// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL = 6'h00,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	typedef enum logic [3:0] {
		ALU_AND = 4'h0,
		ALU_OR  = 4'h1,
		ALU_ADD = 4'h2,
		ALU_SUB = 4'h6,
		ALU_SLT = 4'h7,
		ALU_SLL = 4'h8
	} alu_op_e;

	// Operation family picked by the main decoder.
	typedef enum logic [1:0] {
		CLS_ADD   = 2'b00, // Address arithmetic for loads and stores.
		CLS_SUB   = 2'b01, // Compare for beq.
		CLS_FUNCT = 2'b10  // R-type, the funct field decides.
	} alu_class_e;

	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  shamt;
		logic [5:0]  funct;
	} r_view_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_view_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] target;
	} j_view_t;

	// One instruction word seen through the three MIPS formats.
	typedef union packed {
		r_view_t r;
		i_view_t i;
		j_view_t j;
	} instr_t;

endpackage

`default_nettype wire

// ==== rtl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	import isa_pkg::*;

	typedef struct packed {
		logic       regwrite;
		logic       regdst;    // Destination is rd when set, rt otherwise.
		logic       memtoreg;
		logic       memread;
		logic       memwrite;
		logic       isbranch;
		logic       isjump;
		logic       alusrc;    // Second ALU operand is the immediate when set.
		alu_class_e alu_class;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] pc_next;
		instr_t      instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic [31:0] pc_next;
		logic [31:0] rs_data;
		logic [31:0] rt_data;
		logic [31:0] imm;
		logic [31:0] jump_target;
		logic [4:0]  rt;
		logic [4:0]  rd;
	} id_ex_t;

	typedef struct packed {
		logic        regwrite;
		logic        memtoreg;
		logic        memread;
		logic        memwrite;
		logic        isbranch;
		logic [31:0] branch_target;
		logic        zero;
		logic [31:0] alu_result;
		logic [31:0] store_data;
		logic [4:0]  dst;
	} ex_mem_t;

	typedef struct packed {
		logic        regwrite;
		logic        memtoreg;
		logic [31:0] load_data;
		logic [31:0] alu_result;
		logic [4:0]  dst;
	} mem_wb_t;

	typedef struct packed {
		logic [4:0]  rd;
		logic [31:0] data;
	} wb_port_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} store_port_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defines.svh"

module fetch_stage import pipe_pkg::*; (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                prog_we,
	input  wire logic [`IMEM_AW-1:0] prog_addr,
	input  wire logic [31:0]         prog_data,
	input  wire logic                jump_taken,
	input  wire logic [31:0]         jump_target,
	input  wire logic                branch_taken,
	input  wire logic [31:0]         branch_target,
	output if_id_t                   if_id
);

	logic [31:0] pc;
	logic [31:0] pc_d;
	logic [31:0] pc_plus4;
	logic [31:0] instr;
	logic [31:0] imem [2**`IMEM_AW];

	assign pc_plus4 = pc + 32'd4;
	assign instr = imem[pc[`IMEM_AW+1:2]]; // Word-addressed, byte offset dropped.

	// A branch is older than a jump, so it wins.
	always_comb begin
		if (branch_taken) begin
			pc_d = branch_target;
		end else if (jump_taken) begin
			pc_d = jump_target;
		end else begin
			pc_d = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `RESET_PC;
		end else begin
			pc <= pc_d;
		end
	end

	always_ff @(posedge clk) begin
		if (prog_we) begin
			imem[prog_addr] <= prog_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || jump_taken || branch_taken) begin
			if_id <= '0; // An all-zero word decodes as sll r0, which is a nop.
		end else begin
			if_id.pc_next <= pc_plus4;
			if_id.instr <= instr;
		end
	end

	pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
		else $error("PC is not word-aligned: %h", pc);

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire if_id_t   if_id,
	input  wire logic     flush,
	input  wire logic     wb_we,
	input  wire wb_port_t wb,
	output id_ex_t        id_ex
);

	ctrl_t       ctrl;
	logic [31:0] regs [32];
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] imm;
	logic [31:0] jump_target;

	always_comb begin
		ctrl = '0;
		case (if_id.instr.r.opcode)
			OP_RTYPE: begin
				ctrl.regwrite = 1'b1;
				ctrl.regdst = 1'b1;
				ctrl.alu_class = CLS_FUNCT;
			end
			OP_ADDI: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.alu_class = CLS_ADD;
			end
			OP_LW: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.alu_class = CLS_ADD;
			end
			OP_SW: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc = 1'b1;
				ctrl.alu_class = CLS_ADD;
			end
			OP_BEQ: begin
				ctrl.isbranch = 1'b1;
				ctrl.alu_class = CLS_SUB;
			end
			OP_J: begin
				ctrl.isjump = 1'b1;
			end
			default: begin
				ctrl = '0; // Unknown opcodes retire as nops.
			end
		endcase
	end

	// Register 0 is never written, so its slot is masked on read.
	assign rs_data = (if_id.instr.i.rs == 5'd0) ? 32'd0 : regs[if_id.instr.i.rs];
	assign rt_data = (if_id.instr.i.rt == 5'd0) ? 32'd0 : regs[if_id.instr.i.rt];

	assign imm = {{16{if_id.instr.i.imm[15]}}, if_id.instr.i.imm};
	assign jump_target = {if_id.pc_next[31:28], if_id.instr.j.target, 2'b00};

	always_ff @(posedge clk) begin
		if (wb_we && wb.rd != 5'd0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	always_ff @(posedge clk) begin
		id_ex.pc_next <= if_id.pc_next;
		id_ex.rs_data <= rs_data;
		id_ex.rt_data <= rt_data;
		id_ex.imm <= imm;
		id_ex.jump_target <= jump_target;
		id_ex.rt <= if_id.instr.i.rt;
		id_ex.rd <= if_id.instr.r.rd;
		if (!rst_n || flush) begin
			id_ex.ctrl <= '0;
		end else begin
			id_ex.ctrl <= ctrl;
		end
	end

	// The write-back strobe comes from the memory stage.
	no_r0_write: assert property (@(posedge clk) disable iff (!rst_n) wb_we |-> wb.rd != 5'd0)
		else $error("Write-back strobe raised for register 0.");

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire id_ex_t id_ex,
	input  wire logic   flush,
	output logic        jump_taken,
	output logic [31:0] jump_target,
	output ex_mem_t     ex_mem
);

	funct_e      funct;
	alu_op_e     alu_op;
	logic [4:0]  shamt;
	logic [31:0] op_b;
	logic [31:0] alu_result;
	logic [4:0]  dst;
	logic [31:0] branch_target;

	assign funct = funct_e'(id_ex.imm[5:0]); // The R-type fields sit in the low immediate bits.
	assign shamt = id_ex.imm[10:6];

	always_comb begin
		case (id_ex.ctrl.alu_class)
			CLS_ADD: alu_op = ALU_ADD;
			CLS_SUB: alu_op = ALU_SUB;
			default: begin
				case (funct)
					FN_ADD: alu_op = ALU_ADD;
					FN_SUB: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR: alu_op = ALU_OR;
					FN_SLT: alu_op = ALU_SLT;
					FN_SLL: alu_op = ALU_SLL;
					default: alu_op = ALU_ADD;
				endcase
			end
		endcase
	end

	assign op_b = id_ex.ctrl.alusrc ? id_ex.imm : id_ex.rt_data;

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_result = id_ex.rs_data + op_b;
			ALU_SUB: alu_result = id_ex.rs_data - op_b;
			ALU_AND: alu_result = id_ex.rs_data & op_b;
			ALU_OR: alu_result = id_ex.rs_data | op_b;
			ALU_SLT: alu_result = {31'd0, $signed(id_ex.rs_data) < $signed(op_b)};
			ALU_SLL: alu_result = op_b << shamt; // Shifts rt, rs is ignored.
			default: alu_result = 32'd0;
		endcase
	end

	assign dst = id_ex.ctrl.regdst ? id_ex.rd : id_ex.rt;
	assign branch_target = id_ex.pc_next + {id_ex.imm[29:0], 2'b00};

	// A flushed slot has its control bits cleared, so only a live jump gets here.
	assign jump_taken = id_ex.ctrl.isjump;
	assign jump_target = id_ex.jump_target;

	always_ff @(posedge clk) begin
		ex_mem.branch_target <= branch_target;
		ex_mem.zero <= (alu_result == 32'd0);
		ex_mem.alu_result <= alu_result;
		ex_mem.store_data <= id_ex.rt_data;
		ex_mem.dst <= dst;
		if (!rst_n || flush) begin
			ex_mem.regwrite <= 1'b0;
			ex_mem.memtoreg <= 1'b0;
			ex_mem.memread <= 1'b0;
			ex_mem.memwrite <= 1'b0;
			ex_mem.isbranch <= 1'b0;
		end else begin
			ex_mem.regwrite <= id_ex.ctrl.regwrite;
			ex_mem.memtoreg <= id_ex.ctrl.memtoreg;
			ex_mem.memread <= id_ex.ctrl.memread;
			ex_mem.memwrite <= id_ex.ctrl.memwrite;
			ex_mem.isbranch <= id_ex.ctrl.isbranch;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/memory_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defines.svh"

module memory_stage import pipe_pkg::*; (
	input  wire logic    clk,
	input  wire logic    rst_n,
	input  wire ex_mem_t ex_mem,
	output logic         branch_taken,
	output logic [31:0]  branch_target,
	output logic         wb_we,
	output wb_port_t     wb,
	output logic         store_valid,
	output store_port_t  store
);

	logic [31:0]         dmem [2**`DMEM_AW];
	logic [`DMEM_AW-1:0] word_addr;
	logic [31:0]         load_data;
	mem_wb_t             mem_wb;

	assign word_addr = ex_mem.alu_result[`DMEM_AW+1:2];
	assign load_data = ex_mem.memread ? dmem[word_addr] : 32'd0;

	always_ff @(posedge clk) begin
		if (ex_mem.memwrite) begin
			dmem[word_addr] <= ex_mem.store_data;
		end
	end

	assign branch_taken = ex_mem.isbranch && ex_mem.zero; // Equal operands subtract to zero.
	assign branch_target = ex_mem.branch_target;

	assign store_valid = ex_mem.memwrite;
	assign store.addr = ex_mem.alu_result;
	assign store.data = ex_mem.store_data;

	always_ff @(posedge clk) begin
		mem_wb.load_data <= load_data;
		mem_wb.alu_result <= ex_mem.alu_result;
		mem_wb.dst <= ex_mem.dst;
		if (!rst_n) begin
			mem_wb.regwrite <= 1'b0;
			mem_wb.memtoreg <= 1'b0;
		end else begin
			mem_wb.regwrite <= ex_mem.regwrite;
			mem_wb.memtoreg <= ex_mem.memtoreg;
		end
	end

	// Writes to register 0 leave no trace at all.
	assign wb_we = mem_wb.regwrite && (mem_wb.dst != 5'd0);
	assign wb.rd = mem_wb.dst;
	assign wb.data = mem_wb.memtoreg ? mem_wb.load_data : mem_wb.alu_result;

	rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(ex_mem.memread && ex_mem.memwrite))
		else $error("Data memory read and write requested together.");

endmodule

`default_nettype wire

// ==== rtl/cpu.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu import pipe_pkg::*; (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                prog_we,
	input  wire logic [`IMEM_AW-1:0] prog_addr,
	input  wire logic [31:0]         prog_data,
	output logic                     wb_valid,
	output wb_port_t                 wb,
	output logic                     store_valid,
	output store_port_t              store
);

	if_id_t      if_id;
	id_ex_t      id_ex;
	ex_mem_t     ex_mem;
	logic        jump_taken;
	logic [31:0] jump_target;
	logic        branch_taken;
	logic [31:0] branch_target;
	logic        id_flush;
	logic        ex_flush;

	assign id_flush = jump_taken | branch_taken;
	assign ex_flush = branch_taken; // A jump leaves itself in execute/memory as a nop.

	fetch_stage fetch_i (
		.clk(clk),
		.rst_n(rst_n),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.jump_taken(jump_taken),
		.jump_target(jump_target),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.if_id(if_id)
	);

	decode_stage decode_i (
		.clk(clk),
		.rst_n(rst_n),
		.if_id(if_id),
		.flush(id_flush),
		.wb_we(wb_valid),
		.wb(wb),
		.id_ex(id_ex)
	);

	execute_stage execute_i (
		.clk(clk),
		.rst_n(rst_n),
		.id_ex(id_ex),
		.flush(ex_flush),
		.jump_taken(jump_taken),
		.jump_target(jump_target),
		.ex_mem(ex_mem)
	);

	memory_stage memory_i (
		.clk(clk),
		.rst_n(rst_n),
		.ex_mem(ex_mem),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.wb_we(wb_valid),
		.wb(wb),
		.store_valid(store_valid),
		.store(store)
	);

endmodule

`default_nettype wire

// ==== testbench/cpu_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_tb import pipe_pkg::*; ();

	localparam int FIRST_WB_CYCLE = 4; // Fetch, decode, execute and memory come first.
	localparam int DRAIN_CYCLES = 10;

	logic                clk;
	logic                rst_n;
	logic                prog_we;
	logic [`IMEM_AW-1:0] prog_addr;
	logic [31:0]         prog_data;
	logic                wb_valid;
	wb_port_t            wb;
	logic                store_valid;
	store_port_t         store;

	logic [31:0] testdata [256];
	wb_port_t    wb_exp [$];
	int          wb_test [$];
	store_port_t store_exp [$];
	int          store_test [$];
	int          checks [7]; // Indexed by test number, slot 0 is unused.
	int          errors [7];
	int          left [7];
	int          extra;
	int          run_cycle;
	bit          first_seen;

	cpu cpu_i (
		.clk(clk),
		.rst_n(rst_n),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.wb_valid(wb_valid),
		.wb(wb),
		.store_valid(store_valid),
		.store(store)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic string test_name(input int t);
		case (t)
			1: return "quiet until the first retire";
			2: return "addi and ALU operations";
			3: return "store then load";
			4: return "taken and not-taken beq";
			5: return "jump";
			6: return "register 0";
			default: return "unknown";
		endcase
	endfunction

	task automatic check_wb(input wb_port_t expected, input wb_port_t actual, input int t);
		checks[t]++;
		if (actual.rd !== expected.rd) begin
			$display("error at %0d ns: wb.rd expected %0d, actual %0d",
				$time, expected.rd, actual.rd);
			errors[t]++;
		end
		if (actual.data !== expected.data) begin
			$display("error at %0d ns: wb.data expected %h, actual %h",
				$time, expected.data, actual.data);
			errors[t]++;
		end
	endtask

	task automatic check_store(input store_port_t expected, input store_port_t actual,
			input int t);
		checks[t]++;
		if (actual.addr !== expected.addr) begin
			$display("error at %0d ns: store.addr expected %h, actual %h",
				$time, expected.addr, actual.addr);
			errors[t]++;
		end
		if (actual.data !== expected.data) begin
			$display("error at %0d ns: store.data expected %h, actual %h",
				$time, expected.data, actual.data);
			errors[t]++;
		end
	endtask

	task automatic retire(input int t);
		left[t]--;
		if (left[t] == 0) begin
			$display("test %0d, %s: %0d checks, %0d errors",
				t, test_name(t), checks[t], errors[t]);
		end
	endtask

	// Outputs are sampled on the falling edge, half a cycle after they change.
	initial begin : monitor
		wb_port_t    w;
		store_port_t s;
		int          t;

		forever begin
			@(negedge clk);
			if (!rst_n) begin
				if (wb_valid || store_valid) begin
					$display("A result strobe was raised while the core was in reset at %0d ns.",
						$time);
					errors[1]++;
				end
			end else begin
				if (wb_valid && !first_seen) begin
					first_seen = 1'b1;
					checks[1]++;
					if (run_cycle != FIRST_WB_CYCLE) begin
						$display("error at %0d ns: wb_valid first cycle expected %0d, actual %0d",
							$time, FIRST_WB_CYCLE, run_cycle);
						errors[1]++;
					end
					retire(1);
				end
				if (wb_valid) begin
					if (wb_exp.size() == 0) begin
						$display("A register write to r%0d at %0d ns was not expected.",
							wb.rd, $time);
						extra++;
					end else begin
						w = wb_exp.pop_front();
						t = wb_test.pop_front();
						check_wb(w, wb, t);
						retire(t);
					end
				end
				if (store_valid) begin
					if (store_exp.size() == 0) begin
						$display("A store to address %h at %0d ns was not expected.",
							store.addr, $time);
						extra++;
					end else begin
						s = store_exp.pop_front();
						t = store_test.pop_front();
						check_store(s, store, t);
						retire(t);
					end
				end
				run_cycle++;
			end
		end
	end

	initial begin : main
		int          n_prog;
		int          idx;
		int          t;
		int          i;
		int          reset_cycles;
		int          total_checks;
		int          total_errors;
		wb_port_t    w;
		store_port_t s;

		rst_n = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		$readmemh("testbench/cpu_testdata.txt", testdata);
		n_prog = testdata[0];
		idx = 1 + n_prog;
		while (testdata[idx][7:0] != 8'h00) begin // A zero tag closes the record list.
			t = int'(testdata[idx][15:8]);
			left[t]++;
			if (testdata[idx][7:0] == 8'h01) begin
				w.rd = testdata[idx + 1][4:0];
				w.data = testdata[idx + 2];
				wb_exp.push_back(w);
				wb_test.push_back(t);
			end else begin
				s.addr = testdata[idx + 1];
				s.data = testdata[idx + 2];
				store_exp.push_back(s);
				store_test.push_back(t);
			end
			idx += 3;
		end
		left[1] = 1;

		// The core stays in reset for at least 10 cycles and until the last word is in.
		reset_cycles = (n_prog > 10) ? n_prog : 10;
		for (i = 0; i < reset_cycles; i++) begin
			@(posedge clk);
			prog_we <= (i < n_prog);
			prog_addr <= `IMEM_AW'(i);
			prog_data <= testdata[1 + i];
		end
		@(posedge clk);
		prog_we <= 1'b0;
		rst_n <= 1'b1;

		while (wb_exp.size() != 0 || store_exp.size() != 0) begin
			@(posedge clk);
		end
		repeat (DRAIN_CYCLES) @(posedge clk); // Late extra results still get caught.

		total_checks = 0;
		total_errors = extra;
		for (i = 1; i <= 6; i++) begin
			total_checks += checks[i];
			total_errors += errors[i];
		end
		$display("%0d checks, %0d errors, %0d of them unexpected results",
			total_checks, total_errors, extra);
		if (total_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin : watchdog
		@(posedge clk);
		repeat (20 * testdata[0] + 100) @(posedge clk); // Twenty cycles per word plus margin.
		$display("Timeout: %0d register writes and %0d stores never arrived.",
			wb_exp.size(), store_exp.size());
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/cpu_testdata.txt ====
// Word 0 is the program length, then the program words. Then records of three columns:
// tag (test << 8 | kind, kind 1 = register write, 2 = store), register or address, data.
0000001C
20010005 // addi r1, r0, 5
2002FFFD // addi r2, r0, -3
20000007 // addi r0, r0, 7
2003000C // addi r3, r0, 12
00000000 00000000 00000000 // nops
00222020 // add r4, r1, r2
00222822 // sub r5, r1, r2
00233024 // and r6, r1, r3
00233825 // or r7, r1, r3
0041402A // slt r8, r2, r1
00014900 // sll r9, r1, 4
00015020 // add r10, r0, r1
AC670004 // sw r7, 4(r3)
AC61FFFC // sw r1, -4(r3)
8C6B0004 // lw r11, 4(r3)
102A0003 // beq r1, r10, +3 taken
200C0001 200D0001 200E0001 // discarded by the branch
10220001 // beq r1, r2, +1 not taken
200F0021 // addi r15, r0, 0x21
0800001A // j 26
20100001 20110001 // discarded by the jump
20120042 // addi r18, r0, 0x42
0800001B // j 27 spins here
00000201 00000001 00000005
00000201 00000002 FFFFFFFD
00000201 00000003 0000000C
00000201 00000004 00000002
00000201 00000005 00000008
00000201 00000006 00000004
00000201 00000007 0000000D
00000201 00000008 00000001
00000201 00000009 00000050
00000601 0000000A 00000005
00000302 00000010 0000000D
00000302 00000008 00000005
00000301 0000000B 0000000D
00000401 0000000F 00000021
00000501 00000012 00000042
00000000

// ==== build.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu.sv
testbench/cpu_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = cpu_tb
RTL_TOP    = cpu
FILELIST   = build.f
PASS_MSG   = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
